// File: rtl/bmc_macros.svh
`ifndef BMC_MACROS_SVH
`define BMC_MACROS_SVH

// write data beat width
`define BMC_DATA_WIDTH 64

// masters served by this slave port
`define BMC_NUM_MST 4
`define BMC_MST_IDX_WIDTH 2

// slave id carried with each beat and response
`define BMC_SID_WIDTH 5

// transaction id, master index excluded
`define BMC_ID_WIDTH 4
`define BMC_RESP_WIDTH 2

// addresses allowed in flight, at least 2
`define BMC_OUTSTANDING_DEPTH 2

`endif

// File: rtl/bmc_pkg.sv
`include "bmc_macros.svh"

package bmc_pkg;

	// one write beat and its byte strobes
	typedef logic [`BMC_DATA_WIDTH-1:0] data_t;
	typedef logic [`BMC_DATA_WIDTH/8-1:0] strb_t;

	// slave id compared against self_id
	typedef logic [`BMC_SID_WIDTH-1:0] sid_t;

	// index of an issuing master
	typedef logic [`BMC_MST_IDX_WIDTH-1:0] mst_idx_t;

	// response id, master index sits in the low bits
	typedef logic [`BMC_ID_WIDTH+`BMC_MST_IDX_WIDTH-1:0] bid_t;

	// write response code
	typedef logic [`BMC_RESP_WIDTH-1:0] resp_t;

endpackage

// File: rtl/mst_port_filter.sv
`timescale 1ns/1ps
`include "bmc_macros.svh"

module mst_port_filter (
	input  bmc_pkg::sid_t             self_id,
	input  logic [`BMC_NUM_MST-1:0]   mst_connect,
	input  logic [`BMC_NUM_MST-1:0]   mst_wvalid,
	input  logic [`BMC_NUM_MST-1:0]   mst_wlast,
	input  logic [`BMC_NUM_MST-1:0]   mst_bready,
	input  bmc_pkg::sid_t             mst_wsid [`BMC_NUM_MST],
	input  bmc_pkg::sid_t             mst_bsid [`BMC_NUM_MST],
	input  bmc_pkg::data_t            mst_wdata [`BMC_NUM_MST],
	input  bmc_pkg::strb_t            mst_wstrb [`BMC_NUM_MST],
	output logic [`BMC_NUM_MST-1:0]   flt_wvalid,
	output logic [`BMC_NUM_MST-1:0]   flt_wlast,
	output logic [`BMC_NUM_MST-1:0]   flt_bready,
	output bmc_pkg::data_t            flt_wdata [`BMC_NUM_MST],
	output bmc_pkg::strb_t            flt_wstrb [`BMC_NUM_MST]
);

	always_comb begin
		for (int i = 0; i < `BMC_NUM_MST; i++) begin
			// disconnected masters present an all-zero beat
			if (mst_connect[i]) begin
				flt_wdata[i] = mst_wdata[i];
				flt_wstrb[i] = mst_wstrb[i];
			end else begin
				flt_wdata[i] = '0;
				flt_wstrb[i] = '0;
			end
			flt_wlast[i] = mst_wlast[i] & mst_connect[i];

			// handshakes only count when aimed at this port
			flt_wvalid[i] = mst_wvalid[i] & mst_connect[i] &
				(mst_wsid[i] == self_id);
			flt_bready[i] = mst_bready[i] & mst_connect[i] &
				(mst_bsid[i] == self_id);
		end
	end

endmodule

// File: rtl/wmid_fifo.sv
`timescale 1ns/1ps
`include "bmc_macros.svh"

module wmid_fifo #(
	parameter int depth = `BMC_OUTSTANDING_DEPTH
) (
	input  logic              aclk,
	input  logic              aresetn,
	input  logic              push,
	input  bmc_pkg::mst_idx_t push_idx,
	input  logic              pop,
	output bmc_pkg::mst_idx_t head,
	output logic              empty,
	output logic              full
);

	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	bmc_pkg::mst_idx_t mem [depth];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [cnt_w-1:0]  occ;
	logic              do_push;
	logic              do_pop;

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	assign empty = (occ == '0);
	assign full  = (occ == cnt_w'(depth));
	assign head  = mem[rd_ptr];

	// index storage, written in address order
	always_ff @(posedge aclk) begin
		if (do_push)
			mem[wr_ptr] <= push_idx;
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ    <= '0;
		end else begin
			// pointers wrap explicitly, depth need not be a power of two
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push & ~do_pop)
				occ <= occ + 1'b1;
			else if (do_pop & ~do_push)
				occ <= occ - 1'b1;
		end
	end

endmodule

// File: rtl/wdata_route.sv
`timescale 1ns/1ps
`include "bmc_macros.svh"

module wdata_route (
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic [`BMC_NUM_MST-1:0]   flt_wvalid,
	input  logic [`BMC_NUM_MST-1:0]   flt_wlast,
	input  bmc_pkg::data_t            flt_wdata [`BMC_NUM_MST],
	input  bmc_pkg::strb_t            flt_wstrb [`BMC_NUM_MST],
	input  bmc_pkg::mst_idx_t         head,
	input  logic                      queue_empty,
	input  logic                      count_full,
	input  logic                      ds_wready,
	output logic                      slv_wready,
	output logic                      last_wr,
	output logic                      ds_wvalid,
	output logic                      ds_wlast,
	output bmc_pkg::data_t            ds_wdata,
	output bmc_pkg::strb_t            ds_wstrb
);

	logic wvalid_sel;
	logic wlast_sel;
	logic out_busy;
	logic beat_acc;

	// beat of the master at the head of the order queue
	assign wvalid_sel = flt_wvalid[head];
	assign wlast_sel  = flt_wlast[head];

	// output register still holds a beat the slave has not taken
	assign out_busy = ds_wvalid & ~ds_wready;

	// last beat waits while too many bursts await their response
	assign slv_wready = ~out_busy & ~queue_empty & ~(wlast_sel & count_full);

	assign beat_acc = slv_wready & wvalid_sel;
	assign last_wr  = beat_acc & wlast_sel;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			ds_wvalid <= 1'b0;
		else
			ds_wvalid <= beat_acc | out_busy;
	end

	// payload follows the accepted beat
	always_ff @(posedge aclk) begin
		if (beat_acc) begin
			ds_wdata <= flt_wdata[head];
			ds_wstrb <= flt_wstrb[head];
			ds_wlast <= wlast_sel;
		end
	end

endmodule

// File: rtl/bresp_route.sv
`timescale 1ns/1ps
`include "bmc_macros.svh"

module bresp_route (
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic                      ds_bvalid,
	input  bmc_pkg::bid_t             ds_bid,
	input  bmc_pkg::resp_t            ds_bresp,
	input  logic [`BMC_NUM_MST-1:0]   flt_bready,
	input  logic                      last_wr,
	output logic                      ds_bready,
	output logic                      slv_bvalid,
	output bmc_pkg::bid_t             slv_bid,
	output bmc_pkg::resp_t            slv_bresp,
	output logic                      count_full
);

	localparam int depth = `BMC_OUTSTANDING_DEPTH;
	localparam int cnt_w = $clog2(depth + 1);

	logic             pend_valid;
	bmc_pkg::bid_t    pend_bid;
	bmc_pkg::resp_t   pend_bresp;
	logic [cnt_w-1:0] resp_cnt;
	logic             cnt_empty;
	logic             b_done;

	// slave may hand over a new response only into an empty buffer
	assign ds_bready = ~pend_valid;

	// held response has priority over the live one
	assign slv_bid    = pend_valid ? pend_bid : ds_bid;
	assign slv_bresp  = pend_valid ? pend_bresp : ds_bresp;
	assign slv_bvalid = (pend_valid | ds_bvalid) & ~cnt_empty;

	// low id bits name the master that owns the response
	assign b_done = slv_bvalid & flt_bready[slv_bid[`BMC_MST_IDX_WIDTH-1:0]];

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			pend_valid <= 1'b0;
		else
			pend_valid <= (pend_valid | ds_bvalid) & ~b_done;
	end

	// capture a live response the master did not take
	always_ff @(posedge aclk) begin
		if (ds_bvalid & ds_bready & ~b_done) begin
			pend_bid   <= ds_bid;
			pend_bresp <= ds_bresp;
		end
	end

	// bursts fully written but not yet answered
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			resp_cnt <= '0;
		else if (last_wr & ~b_done)
			resp_cnt <= resp_cnt + 1'b1;
		else if (b_done & ~last_wr)
			resp_cnt <= resp_cnt - 1'b1;
	end

	assign cnt_empty  = (resp_cnt == '0);
	assign count_full = (resp_cnt == cnt_w'(depth));

endmodule

// File: rtl/ds_wdata_bresp_ctrl.sv
`timescale 1ns/1ps
`include "bmc_macros.svh"

module ds_wdata_bresp_ctrl (
	input  logic                      aclk,
	input  logic                      aresetn,
	input  bmc_pkg::sid_t             self_id,

	// per-master write and response-ready inputs
	input  logic [`BMC_NUM_MST-1:0]   mst_connect,
	input  logic [`BMC_NUM_MST-1:0]   mst_wvalid,
	input  logic [`BMC_NUM_MST-1:0]   mst_wlast,
	input  logic [`BMC_NUM_MST-1:0]   mst_bready,
	input  bmc_pkg::sid_t             mst_wsid [`BMC_NUM_MST],
	input  bmc_pkg::sid_t             mst_bsid [`BMC_NUM_MST],
	input  bmc_pkg::data_t            mst_wdata [`BMC_NUM_MST],
	input  bmc_pkg::strb_t            mst_wstrb [`BMC_NUM_MST],

	// address order from the address channel
	input  bmc_pkg::mst_idx_t         slv_aid,
	input  logic                      addr_outstanding_en,
	output logic                      outstanding_ready,
	output bmc_pkg::mst_idx_t         slv_wmid,
	output logic                      slv_wready,

	// downstream write data
	output logic                      ds_wvalid,
	output logic                      ds_wlast,
	output bmc_pkg::data_t            ds_wdata,
	output bmc_pkg::strb_t            ds_wstrb,
	input  logic                      ds_wready,

	// downstream write response
	input  logic                      ds_bvalid,
	input  bmc_pkg::bid_t             ds_bid,
	input  bmc_pkg::resp_t            ds_bresp,
	output logic                      ds_bready,

	// response toward the masters
	output logic                      slv_bvalid,
	output bmc_pkg::bid_t             slv_bid,
	output bmc_pkg::resp_t            slv_bresp
);

	logic [`BMC_NUM_MST-1:0] flt_wvalid;
	logic [`BMC_NUM_MST-1:0] flt_wlast;
	logic [`BMC_NUM_MST-1:0] flt_bready;
	bmc_pkg::data_t          flt_wdata [`BMC_NUM_MST];
	bmc_pkg::strb_t          flt_wstrb [`BMC_NUM_MST];
	bmc_pkg::mst_idx_t       q_head;
	logic                    q_empty;
	logic                    q_full;
	logic                    last_wr;
	logic                    count_full;

	assign outstanding_ready = ~q_full;
	assign slv_wmid          = q_head;

	mst_port_filter u_mst_port_filter (
		.self_id     (self_id),
		.mst_connect (mst_connect),
		.mst_wvalid  (mst_wvalid),
		.mst_wlast   (mst_wlast),
		.mst_bready  (mst_bready),
		.mst_wsid    (mst_wsid),
		.mst_bsid    (mst_bsid),
		.mst_wdata   (mst_wdata),
		.mst_wstrb   (mst_wstrb),
		.flt_wvalid  (flt_wvalid),
		.flt_wlast   (flt_wlast),
		.flt_bready  (flt_bready),
		.flt_wdata   (flt_wdata),
		.flt_wstrb   (flt_wstrb)
	);

	// popped by the last beat of each burst
	wmid_fifo #(
		.depth (`BMC_OUTSTANDING_DEPTH)
	) u_wmid_fifo (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.push     (addr_outstanding_en),
		.push_idx (slv_aid),
		.pop      (last_wr),
		.head     (q_head),
		.empty    (q_empty),
		.full     (q_full)
	);

	wdata_route u_wdata_route (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.flt_wvalid  (flt_wvalid),
		.flt_wlast   (flt_wlast),
		.flt_wdata   (flt_wdata),
		.flt_wstrb   (flt_wstrb),
		.head        (q_head),
		.queue_empty (q_empty),
		.count_full  (count_full),
		.ds_wready   (ds_wready),
		.slv_wready  (slv_wready),
		.last_wr     (last_wr),
		.ds_wvalid   (ds_wvalid),
		.ds_wlast    (ds_wlast),
		.ds_wdata    (ds_wdata),
		.ds_wstrb    (ds_wstrb)
	);

	bresp_route u_bresp_route (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.ds_bvalid  (ds_bvalid),
		.ds_bid     (ds_bid),
		.ds_bresp   (ds_bresp),
		.flt_bready (flt_bready),
		.last_wr    (last_wr),
		.ds_bready  (ds_bready),
		.slv_bvalid (slv_bvalid),
		.slv_bid    (slv_bid),
		.slv_bresp  (slv_bresp),
		.count_full (count_full)
	);

endmodule

// File: test/tb_ds_wdata_bresp_ctrl.sv
`timescale 1ns/1ps
`include "bmc_macros.svh"

module tb_ds_wdata_bresp_ctrl;

	localparam int n_rows = 6;
	localparam int depth = `BMC_OUTSTANDING_DEPTH;
	localparam int block_cycles = 8;
	localparam int pair_timeout = 400;
	localparam bmc_pkg::sid_t self_sid = 5'h0b;

	logic                    aclk;
	logic                    aresetn;
	bmc_pkg::sid_t           self_id;
	logic [`BMC_NUM_MST-1:0] mst_connect;
	logic [`BMC_NUM_MST-1:0] mst_wvalid;
	logic [`BMC_NUM_MST-1:0] mst_wlast;
	logic [`BMC_NUM_MST-1:0] mst_bready;
	bmc_pkg::sid_t           mst_wsid [`BMC_NUM_MST];
	bmc_pkg::sid_t           mst_bsid [`BMC_NUM_MST];
	bmc_pkg::data_t          mst_wdata [`BMC_NUM_MST];
	bmc_pkg::strb_t          mst_wstrb [`BMC_NUM_MST];
	bmc_pkg::mst_idx_t       slv_aid;
	logic                    addr_outstanding_en;
	logic                    outstanding_ready;
	bmc_pkg::mst_idx_t       slv_wmid;
	logic                    slv_wready;
	logic                    ds_wvalid;
	logic                    ds_wlast;
	bmc_pkg::data_t          ds_wdata;
	bmc_pkg::strb_t          ds_wstrb;
	logic                    ds_wready;
	logic                    ds_bvalid;
	bmc_pkg::bid_t           ds_bid;
	bmc_pkg::resp_t          ds_bresp;
	logic                    ds_bready;
	logic                    slv_bvalid;
	bmc_pkg::bid_t           slv_bid;
	bmc_pkg::resp_t          slv_bresp;

	// master, beats, data seed, wsid, connect, bresp, bready delay, ds_wready pattern
	// a pattern of zero means random stalls; rows run in pairs of distinct masters
	int             t_mst   [n_rows] = '{0, 2, 1, 3, 2, 0};
	int             t_beats [n_rows] = '{4, 3, 2, 5, 6, 8};
	logic [31:0]    t_seed  [n_rows] = '{32'h1111_0000, 32'h2222_0100, 32'h3333_0200,
		32'h4444_0300, 32'h5555_0400, 32'h6666_0500};
	bmc_pkg::sid_t  t_wsid  [n_rows] = '{5'h0b, 5'h0b, 5'h0b, 5'h0b, 5'h1f, 5'h0b};
	logic           t_conn  [n_rows] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
	bmc_pkg::resp_t t_resp  [n_rows] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd1};
	int             t_bdly  [n_rows] = '{0, 3, 2, 0, 5, 1};
	logic [7:0]     t_stall [n_rows] = '{8'hff, 8'hff, 8'hb6, 8'hff, 8'h00, 8'h00};

	// reference state of the current pair
	int             pb;
	int             cyc;
	int             ptr [2];
	int             bdone;
	int             b_wait;
	int             exp_occ;
	int             resp_cnt;
	logic           ow_valid;
	bmc_pkg::data_t ow_data;
	bmc_pkg::strb_t ow_strb;
	logic           ow_last;
	int             ow_slot;
	int             ds_bq [$];
	int             exp_bq [$];

	ds_wdata_bresp_ctrl u_ds_wdata_bresp_ctrl (.*);

	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	function automatic bmc_pkg::data_t beat_data(int row, int beat);
		return {t_seed[row] + 32'(beat), ~t_seed[row] ^ 32'(beat * 3)};
	endfunction

	function automatic bmc_pkg::strb_t beat_strb(int beat);
		return bmc_pkg::strb_t'(8'hff >> (beat % 4));
	endfunction

	// transaction id is the row, master index in the low bits
	function automatic bmc_pkg::bid_t make_bid(int row);
		return {4'(row), 2'(t_mst[row])};
	endfunction

	// oldest burst of the pair with beats left to accept
	function automatic int head_slot();
		if (ptr[0] < t_beats[pb])
			return 0;
		if (ptr[1] < t_beats[pb + 1])
			return 1;
		return 2;
	endfunction

	task automatic fail_now(string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp)
			fail_now($sformatf("ERROR %s got %h exp %h", name, got, exp));
	endtask

	task automatic check_idx(string name, bmc_pkg::mst_idx_t got, bmc_pkg::mst_idx_t exp);
		if (got !== exp)
			fail_now($sformatf("ERROR %s got %h exp %h", name, got, exp));
	endtask

	task automatic check_beat(bmc_pkg::data_t got_d, bmc_pkg::data_t exp_d,
			bmc_pkg::strb_t got_s, bmc_pkg::strb_t exp_s);
		if (got_d !== exp_d)
			fail_now($sformatf("ERROR ds_wdata got %h exp %h", got_d, exp_d));
		if (got_s !== exp_s)
			fail_now($sformatf("ERROR ds_wstrb got %h exp %h", got_s, exp_s));
	endtask

	task automatic check_resp(bmc_pkg::bid_t got_b, bmc_pkg::bid_t exp_b,
			bmc_pkg::resp_t got_r, bmc_pkg::resp_t exp_r);
		if (got_b !== exp_b)
			fail_now($sformatf("ERROR slv_bid got %h exp %h", got_b, exp_b));
		if (got_r !== exp_r)
			fail_now($sformatf("ERROR slv_bresp got %h exp %h", got_r, exp_r));
	endtask

	task automatic drive_inputs();
		int r;
		int m;
		int st;
		mst_wvalid = '0;
		mst_wlast = '0;
		mst_bready = '0;
		mst_connect = '1;
		for (int i = 0; i < `BMC_NUM_MST; i++)
			mst_wsid[i] = self_sid;
		for (int s = 0; s < 2; s++) begin
			r = pb + s;
			m = t_mst[r];
			// bad wsid or connect holds only at the start of the pair
			if (cyc < block_cycles) begin
				mst_connect[m] = t_conn[r];
				mst_wsid[m] = t_wsid[r];
			end
			if (ptr[s] < t_beats[r]) begin
				mst_wvalid[m] = 1'b1;
				mst_wdata[m] = beat_data(r, ptr[s]);
				mst_wstrb[m] = beat_strb(ptr[s]);
				mst_wlast[m] = (ptr[s] == t_beats[r] - 1);
			end
		end
		addr_outstanding_en = (cyc < 2);
		slv_aid = (cyc < 2) ? 2'(t_mst[pb + cyc]) : '0;

		// stall pattern of the burst now leaving
		st = ow_valid ? ow_slot : head_slot();
		if (st > 1)
			st = 1;
		if (t_stall[pb + st] == 8'h00)
			ds_wready = (($urandom % 3) != 0);
		else
			ds_wready = t_stall[pb + st][cyc % 8];

		ds_bvalid = (ds_bq.size() > 0);
		ds_bid = ds_bvalid ? make_bid(ds_bq[0]) : '0;
		ds_bresp = ds_bvalid ? t_resp[ds_bq[0]] : '0;
		if (exp_bq.size() > 0 && b_wait >= t_bdly[exp_bq[0]])
			mst_bready[t_mst[exp_bq[0]]] = 1'b1;
	endtask

	task automatic sample_check();
		int hs;
		int r;
		int m;
		logic head_last;
		logic exp_wready;
		logic exp_bvalid;
		logic exp_bready;
		logic acc;
		logic take;
		hs = head_slot();
		r = pb + ((hs > 1) ? 1 : hs);
		m = t_mst[r];
		head_last = (hs < 2) && mst_wlast[m] && mst_connect[m];
		// ready drops for a busy register, an empty queue or a held last beat
		exp_wready = !(ow_valid && !ds_wready) && (exp_occ > 0) &&
			!(head_last && (resp_cnt == depth));
		// only delivered bursts are answered
		exp_bvalid = (exp_bq.size() > 0);
		// one handed-over response may wait in the pending buffer
		exp_bready = (exp_bq.size() == ds_bq.size());

		check_flag("outstanding_ready", outstanding_ready, exp_occ < depth);
		if (exp_occ > 0 && hs < 2)
			check_idx("slv_wmid", slv_wmid, 2'(t_mst[r]));
		check_flag("slv_wready", slv_wready, exp_wready);
		check_flag("ds_wvalid", ds_wvalid, ow_valid);
		if (ow_valid) begin
			check_beat(ds_wdata, ow_data, ds_wstrb, ow_strb);
			check_flag("ds_wlast", ds_wlast, ow_last);
		end
		check_flag("ds_bready", ds_bready, exp_bready);
		check_flag("slv_bvalid", slv_bvalid, exp_bvalid);
		if (exp_bvalid)
			check_resp(slv_bid, make_bid(exp_bq[0]), slv_bresp, t_resp[exp_bq[0]]);

		// what the coming edge transfers
		acc = exp_wready && (hs < 2) && mst_wvalid[m] && mst_connect[m] &&
			(mst_wsid[m] == self_sid);
		take = ow_valid & ds_wready;
		if (take && ow_last) begin
			ds_bq.push_back(pb + ow_slot);
			exp_bq.push_back(pb + ow_slot);
		end
		if (acc) begin
			ow_data = beat_data(r, ptr[hs]);
			ow_strb = beat_strb(ptr[hs]);
			ow_last = (ptr[hs] == t_beats[r] - 1);
			ow_slot = hs;
			ptr[hs]++;
			if (ow_last) begin
				exp_occ--;
				resp_cnt++;
			end
		end
		ow_valid = acc | (ow_valid & ~take);
		if (addr_outstanding_en)
			exp_occ++;

		if (exp_bvalid) begin
			m = t_mst[exp_bq[0]];
			if (mst_bready[m] & mst_connect[m]) begin
				void'(exp_bq.pop_front());
				bdone++;
				resp_cnt--;
				b_wait = 0;
			end else begin
				b_wait++;
			end
		end
		if (ds_bvalid & exp_bready)
			void'(ds_bq.pop_front());
	endtask

	task automatic run_pair(int base);
		pb = base;
		cyc = 0;
		ptr = '{0, 0};
		bdone = 0;
		b_wait = 0;
		while (bdone < 2) begin
			if (cyc == pair_timeout)
				fail_now($sformatf("timeout waiting for the bursts of rows %0d and %0d",
					base, base + 1));
			@(posedge aclk);
			#1;
			drive_inputs();
			@(negedge aclk);
			sample_check();
			cyc++;
		end
	endtask

	initial begin
		void'($urandom(87813));
		aresetn = 1'b0;
		self_id = self_sid;
		mst_connect = '1;
		mst_wvalid = '0;
		mst_wlast = '0;
		mst_bready = '0;
		for (int i = 0; i < `BMC_NUM_MST; i++) begin
			mst_wsid[i] = self_sid;
			mst_bsid[i] = self_sid;
			mst_wdata[i] = '0;
			mst_wstrb[i] = '0;
		end
		slv_aid = '0;
		addr_outstanding_en = 1'b0;
		ds_wready = 1'b0;
		ds_bvalid = 1'b0;
		ds_bid = '0;
		ds_bresp = '0;
		ow_valid = 1'b0;
		ow_slot = 0;
		exp_occ = 0;
		resp_cnt = 0;

		repeat (10) @(posedge aclk);
		#1 aresetn = 1'b1;
		@(negedge aclk);
		check_flag("ds_wvalid", ds_wvalid, 1'b0);
		check_flag("slv_bvalid", slv_bvalid, 1'b0);
		check_flag("outstanding_ready", outstanding_ready, 1'b1);

		for (int p = 0; p < n_rows; p += 2)
			run_pair(p);

		$display("All tests passed!");
		$finish;
	end

endmodule

// File: compile.f
+incdir+rtl
rtl/bmc_pkg.sv
rtl/mst_port_filter.sv
rtl/wmid_fifo.sv
rtl/wdata_route.sv
rtl/bresp_route.sv
rtl/ds_wdata_bresp_ctrl.sv
test/tb_ds_wdata_bresp_ctrl.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f \
	--top-module tb_ds_wdata_bresp_ctrl -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
